//--- agu_addr_pipeline.sv
`timescale 1ns/10ps

module agu_addr_pipeline (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_start,
    input  logic                  i_row_en,
    input  logic                  i_part_en,
    input  logic                  i_in_piece_en,
    input  logic                  i_ker_row_en,
    input  logic                  i_col_step,
    input  logic                  i_part_first,
    input  logic                  i_part_last,
    input  agu_conv_pkg::ker_t    i_cur_ker_col,
    input  agu_conv_pkg::addr_t   i_start_addr,
    input  agu_conv_pkg::addr_t   i_one_line_size,
    input  agu_conv_pkg::addr_t   i_stride_line_size,
    input  agu_conv_pkg::piece_t  i_in_xlength,
    input  agu_conv_pkg::pad_t    i_pad,
    input  agu_conv_pkg::stride_t i_stride,
    input  logic                  i_first_tiling,
    output logic                  o_piece_load,
    output logic                  o_entry_wen,
    output agu_conv_pkg::entry_t  o_entry
);

    logic [2:0]          r_start_d;      // Bit n is stage n+1
    logic [2:0]          r_in_piece_d;
    logic [1:0]          r_part_d;
    logic                r_row_d;
    agu_conv_pkg::addr_t r_line_base;    // Stage 1
    agu_conv_pkg::addr_t r_part_off;     // Stage 1, part * 7 * stride
    agu_conv_pkg::addr_t r_piece_addr;   // Stage 2
    agu_conv_pkg::addr_t r_ker_addr;     // Stage 3, pad already removed
    agu_conv_pkg::addr_t c_pad_w;
    agu_conv_pkg::addr_t c_pad_lines;
    agu_conv_pkg::addr_t c_part_stride;

    assign c_pad_w       = agu_conv_pkg::addr_t'(i_pad);
    assign c_pad_lines   = c_pad_w * i_one_line_size;
    assign c_part_stride = agu_conv_pkg::addr_t'(agu_conv_pkg::PE_COLS)
                           * agu_conv_pkg::addr_t'(i_stride);

    // Delay line for start and loop advances
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_start_d    <= '0;
            r_in_piece_d <= '0;
            r_part_d     <= '0;
            r_row_d      <= 1'b0;
            o_entry_wen  <= 1'b0;
        end else begin
            r_start_d    <= {r_start_d[1:0], i_start};
            r_in_piece_d <= {r_in_piece_d[1:0], i_in_piece_en};
            r_part_d     <= {r_part_d[0], i_part_en};
            r_row_d      <= i_row_en;
            o_entry_wen  <= i_col_step;      // Entry lands one cycle after the step
        end
    end

    // -------------------------------------------------------------------------
    // Stage 1: line base and part offset
    // -------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (r_start_d[0])
            r_line_base <= i_first_tiling ? i_start_addr - c_pad_lines : i_start_addr;
        else if (r_row_d)
            r_line_base <= r_line_base + i_stride_line_size;
        // Part index already moved, part zero means wrap
        if (r_start_d[0] || (r_part_d[0] && i_part_first))
            r_part_off <= '0;
        else if (r_part_d[0])
            r_part_off <= r_part_off + c_part_stride;
    end

    // Stage 2: input piece address
    always_ff @(posedge i_clk) begin
        if (r_start_d[1] || r_part_d[1])    // Part covers row advances too
            r_piece_addr <= r_line_base + r_part_off;
        else if (r_in_piece_d[1])
            r_piece_addr <= r_piece_addr + agu_conv_pkg::addr_t'(i_in_xlength);
    end

    // -------------------------------------------------------------------------
    // Stage 3: kernel row address
    // -------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (o_piece_load)
            r_ker_addr <= r_piece_addr - c_pad_w;
        else if (i_ker_row_en)
            r_ker_addr <= r_ker_addr + i_one_line_size;   // Skipped rows count too
    end

    assign o_piece_load = r_start_d[2] || r_in_piece_d[2];

    // Entry assembly
    always_ff @(posedge i_clk) begin
        if (i_col_step)
            o_entry <= {i_part_first, i_part_last, i_cur_ker_col,
                        r_ker_addr + agu_conv_pkg::addr_t'(i_cur_ker_col)};
    end

endmodule

//--- agu_conv_baddr.f
agu_conv_pkg.sv
agu_loop_counters.sv
agu_kernel_sequencer.sv
agu_addr_pipeline.sv
agu_entry_fifo.sv
agu_conv_baddr.sv
agu_conv_baddr_properties.sv
tb_agu_conv_baddr.sv

//--- agu_conv_baddr.sv
`timescale 1ns/10ps

module agu_conv_baddr (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  agu_conv_pkg::addr_t   i_start_addr,
    input  agu_conv_pkg::piece_t  i_in_piece_num,
    input  agu_conv_pkg::piece_t  i_out_piece_num,
    input  agu_conv_pkg::piece_t  i_out_ylength,
    input  agu_conv_pkg::part_t   i_part_num,
    input  agu_conv_pkg::piece_t  i_in_ylength,
    input  agu_conv_pkg::piece_t  i_in_xlength,
    input  logic                  i_first_tiling,
    input  logic                  i_last_tiling,
    input  agu_conv_pkg::addr_t   i_one_line_size,      // x-length * input pieces
    input  agu_conv_pkg::addr_t   i_stride_line_size,   // Line size * stride
    input  agu_conv_pkg::pad_t    i_pad,
    input  agu_conv_pkg::stride_t i_stride,
    input  agu_conv_pkg::ker_t    i_kernel,
    input  logic                  i_start,              // One-cycle pulse
    input  logic                  i_fifo_ren,
    output agu_conv_pkg::addr_t   o_base_addr,
    output agu_conv_pkg::ker_t    o_ker_col,
    output logic [1:0]            o_part_flag,
    output logic                  o_pre_comp_rdy,
    output logic                  o_endf
);

    agu_conv_pkg::ker_t   cur_ker_col;
    agu_conv_pkg::entry_t entry;
    logic                 part_first;
    logic                 part_last;
    logic                 ker_row_last;
    logic                 ker_col_last;
    logic                 ker_row_en;
    logic                 row_en;
    logic                 part_en;
    logic                 in_piece_en;
    logic                 work_done;
    logic                 col_step;
    logic                 row_skip;
    logic                 piece_load;
    logic                 entry_wen;
    logic                 almost_full;

    agu_loop_counters u_loop_counters (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(i_start),
        .i_out_ylength(i_out_ylength), .i_out_piece_num(i_out_piece_num),
        .i_in_piece_num(i_in_piece_num), .i_part_num(i_part_num), .i_kernel(i_kernel),
        .i_col_step(col_step), .i_row_skip(row_skip),
        .o_cur_ker_col(cur_ker_col), .o_part_first(part_first), .o_part_last(part_last),
        .o_ker_row_last(ker_row_last), .o_ker_col_last(ker_col_last),
        .o_ker_row_en(ker_row_en), .o_row_en(row_en), .o_part_en(part_en),
        .o_in_piece_en(in_piece_en), .o_work_done(work_done)
    );

    agu_kernel_sequencer u_kernel_seq (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(i_start),
        .i_piece_load(piece_load), .i_row_en(row_en), .i_in_piece_en(in_piece_en),
        .i_ker_row_last(ker_row_last), .i_ker_col_last(ker_col_last),
        .i_almost_full(almost_full), .i_stride(i_stride), .i_pad(i_pad),
        .i_in_ylength(i_in_ylength), .i_first_tiling(i_first_tiling),
        .i_last_tiling(i_last_tiling), .o_col_step(col_step), .o_row_skip(row_skip)
    );

    agu_addr_pipeline u_addr_pipe (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(i_start),
        .i_row_en(row_en), .i_part_en(part_en), .i_in_piece_en(in_piece_en),
        .i_ker_row_en(ker_row_en), .i_col_step(col_step),
        .i_part_first(part_first), .i_part_last(part_last), .i_cur_ker_col(cur_ker_col),
        .i_start_addr(i_start_addr), .i_one_line_size(i_one_line_size),
        .i_stride_line_size(i_stride_line_size), .i_in_xlength(i_in_xlength),
        .i_pad(i_pad), .i_stride(i_stride), .i_first_tiling(i_first_tiling),
        .o_piece_load(piece_load), .o_entry_wen(entry_wen), .o_entry(entry)
    );

    agu_entry_fifo u_entry_fifo (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(i_start),
        .i_wen(entry_wen), .i_ren(i_fifo_ren), .i_work_done(work_done), .i_entry(entry),
        .o_base_addr(o_base_addr), .o_ker_col(o_ker_col), .o_part_flag(o_part_flag),
        .o_almost_full(almost_full), .o_pre_comp_rdy(o_pre_comp_rdy), .o_endf(o_endf)
    );

endmodule

//--- agu_conv_baddr_properties.sv
`timescale 1ns/10ps

module agu_conv_baddr_properties (
    input logic                    i_clk,
    input logic                    i_rst_n,
    input logic                    i_endf,
    input logic                    i_pre_comp_rdy,
    input logic                    i_entry_wen,
    input agu_conv_pkg::fifo_cnt_t i_fill_count
);

    // ------------------------------------------------------------------------
    // FIFO and end-of-work rules
    // ------------------------------------------------------------------------
    endf_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_endf |-> !i_pre_comp_rdy)
        else $error("o_endf high while an entry is ready");

    count_bound: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_fill_count <= agu_conv_pkg::fifo_cnt_t'(agu_conv_pkg::FIFO_DEPTH))
        else $error("FIFO fill count above depth");

    no_full_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_entry_wen && i_fill_count == agu_conv_pkg::fifo_cnt_t'(agu_conv_pkg::FIFO_DEPTH)))
        else $error("Entry written into a full FIFO");

    rdy_after_reset: assert property (@(posedge i_clk) !i_rst_n |=> !i_pre_comp_rdy)
        else $error("o_pre_comp_rdy high right after reset");

endmodule

bind agu_conv_baddr agu_conv_baddr_properties u_properties (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_endf(o_endf), .i_pre_comp_rdy(o_pre_comp_rdy),
    .i_entry_wen(entry_wen), .i_fill_count(u_entry_fifo.r_count)
);

//--- agu_conv_pkg.sv
package agu_conv_pkg;

    // -------------------------------------------------------------------------
    // Sizes
    // -------------------------------------------------------------------------
    localparam int ADDR_W           = 12;
    localparam int PE_COLS          = 7;               // PE columns per part
    localparam int FIFO_DEPTH       = 16;
    localparam int FIFO_AW          = $clog2(FIFO_DEPTH);
    localparam int FIFO_AFULL_LEVEL = FIFO_DEPTH - 2;  // Room for the write one cycle behind

    // -------------------------------------------------------------------------
    // Vector types
    // -------------------------------------------------------------------------
    typedef logic [ADDR_W-1:0]  addr_t;      // Address, line size or row index
    typedef logic [7:0]         piece_t;     // Piece count, output rows
    typedef logic [4:0]         part_t;
    typedef logic [3:0]         ker_t;       // Kernel size or index
    typedef logic [1:0]         pad_t;
    typedef logic [1:0]         stride_t;
    typedef logic [17:0]        entry_t;     // {first, last, ker col, base addr}
    typedef logic [FIFO_AW-1:0] fifo_ptr_t;
    typedef logic [FIFO_AW:0]   fifo_cnt_t;  // Holds 0 up to FIFO_DEPTH

    // Kernel row sequencer
    typedef enum logic [1:0] {
        KER_IDLE,       // Waiting for a piece address
        KER_ROW_SKIP,   // Row in padding
        KER_COL_RUN,    // Stepping columns
        KER_ROW_INC     // Row pointer moved, pad test valid here
    } ker_state_e;

endpackage

//--- agu_entry_fifo.sv
`timescale 1ns/10ps

module agu_entry_fifo (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_start,
    input  logic                 i_wen,
    input  logic                 i_ren,
    input  logic                 i_work_done,
    input  agu_conv_pkg::entry_t i_entry,
    output agu_conv_pkg::addr_t  o_base_addr,
    output agu_conv_pkg::ker_t   o_ker_col,
    output logic [1:0]           o_part_flag,    // First, last
    output logic                 o_almost_full,
    output logic                 o_pre_comp_rdy,
    output logic                 o_endf
);

    agu_conv_pkg::entry_t    r_mem [agu_conv_pkg::FIFO_DEPTH];
    agu_conv_pkg::fifo_ptr_t r_wr_ptr;
    agu_conv_pkg::fifo_ptr_t r_rd_ptr;
    agu_conv_pkg::fifo_cnt_t r_count;
    agu_conv_pkg::entry_t    c_head;
    logic                    c_wr;
    logic                    c_rd;

    assign c_wr = i_wen && (r_count != agu_conv_pkg::fifo_cnt_t'(agu_conv_pkg::FIFO_DEPTH));
    assign c_rd = i_ren && (r_count != '0);     // Read while empty ignored

    always_ff @(posedge i_clk) begin
        if (c_wr)
            r_mem[r_wr_ptr] <= i_entry;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end else begin
            if (c_wr)
                r_wr_ptr <= r_wr_ptr + 1'b1;    // Power-of-two depth, wraps itself
            if (c_rd)
                r_rd_ptr <= r_rd_ptr + 1'b1;
            case ({c_wr, c_rd})
                2'b10:   r_count <= r_count + 1'b1;
                2'b01:   r_count <= r_count - 1'b1;
                default: r_count <= r_count;
            endcase
        end
    end

    // Show-ahead head word
    assign c_head      = r_mem[r_rd_ptr];
    assign o_base_addr = c_head[agu_conv_pkg::ADDR_W-1:0];
    assign o_ker_col   = c_head[15:12];
    assign o_part_flag = c_head[17:16];

    assign o_pre_comp_rdy = r_count != '0;
    assign o_almost_full  = r_count >= agu_conv_pkg::fifo_cnt_t'(agu_conv_pkg::FIFO_AFULL_LEVEL);
    // Last write may still be in flight when done latches
    assign o_endf = i_work_done && !o_pre_comp_rdy && !i_wen && !i_start;

endmodule

//--- agu_kernel_sequencer.sv
`timescale 1ns/10ps

module agu_kernel_sequencer (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_start,
    input  logic                  i_piece_load,
    input  logic                  i_row_en,
    input  logic                  i_in_piece_en,
    input  logic                  i_ker_row_last,
    input  logic                  i_ker_col_last,
    input  logic                  i_almost_full,
    input  agu_conv_pkg::stride_t i_stride,
    input  agu_conv_pkg::pad_t    i_pad,
    input  agu_conv_pkg::piece_t  i_in_ylength,
    input  logic                  i_first_tiling,
    input  logic                  i_last_tiling,
    output logic                  o_col_step,
    output logic                  o_row_skip
);

    agu_conv_pkg::ker_state_e r_state;
    agu_conv_pkg::ker_state_e c_state_nxt;
    agu_conv_pkg::addr_t      r_row_base;    // Output row times stride
    agu_conv_pkg::addr_t      r_in_row;      // Plus kernel row
    agu_conv_pkg::addr_t      c_pad_w;
    agu_conv_pkg::addr_t      c_ylen_w;
    logic                     c_row_adv;
    logic                     c_pad_row;

    assign c_pad_w  = agu_conv_pkg::addr_t'(i_pad);
    assign c_ylen_w = agu_conv_pkg::addr_t'(i_in_ylength);

    // Padding rows per tiling position
    assign c_pad_row = (i_first_tiling && (r_in_row < c_pad_w))
                       || (i_first_tiling && i_last_tiling && (r_in_row >= c_ylen_w + c_pad_w))
                       || (!i_first_tiling && i_last_tiling && (r_in_row >= c_ylen_w));

    assign c_row_adv = o_row_skip || (o_col_step && i_ker_col_last);

    // -------------------------------------------------------------------------
    // Input row tracking
    // -------------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_row_base <= '0;
            r_in_row   <= '0;
        end else if (i_start) begin
            r_row_base <= '0;
            r_in_row   <= '0;
        end else begin
            if (i_row_en)
                r_row_base <= r_row_base + agu_conv_pkg::addr_t'(i_stride);
            if (i_piece_load)
                r_in_row <= r_row_base;     // Kernel row back to 0
            else if (c_row_adv && !i_in_piece_en)
                r_in_row <= r_in_row + 12'd1;
        end
    end

    // -------------------------------------------------------------------------
    // Kernel row FSM
    // -------------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            r_state <= agu_conv_pkg::KER_IDLE;
        else if (i_start)
            r_state <= agu_conv_pkg::KER_IDLE;
        else
            r_state <= c_state_nxt;
    end

    always_comb begin
        c_state_nxt = r_state;
        case (r_state)
            agu_conv_pkg::KER_IDLE:
                if (i_piece_load)           // Stage 3 settles this cycle
                    c_state_nxt = agu_conv_pkg::KER_ROW_INC;
            agu_conv_pkg::KER_ROW_INC:
                c_state_nxt = c_pad_row ? agu_conv_pkg::KER_ROW_SKIP
                                        : agu_conv_pkg::KER_COL_RUN;
            agu_conv_pkg::KER_ROW_SKIP:
                c_state_nxt = i_ker_row_last ? agu_conv_pkg::KER_IDLE
                                             : agu_conv_pkg::KER_ROW_INC;
            agu_conv_pkg::KER_COL_RUN:
                if (o_col_step && i_ker_col_last)
                    c_state_nxt = i_ker_row_last ? agu_conv_pkg::KER_IDLE
                                                 : agu_conv_pkg::KER_ROW_INC;
            default:
                c_state_nxt = agu_conv_pkg::KER_IDLE;
        endcase
    end

    assign o_col_step = (r_state == agu_conv_pkg::KER_COL_RUN) && !i_almost_full; // Stall
    assign o_row_skip = r_state == agu_conv_pkg::KER_ROW_SKIP;

endmodule

//--- agu_loop_counters.sv
`timescale 1ns/10ps

module agu_loop_counters (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_start,
    input  agu_conv_pkg::piece_t i_out_ylength,
    input  agu_conv_pkg::piece_t i_out_piece_num,
    input  agu_conv_pkg::piece_t i_in_piece_num,
    input  agu_conv_pkg::part_t  i_part_num,
    input  agu_conv_pkg::ker_t   i_kernel,
    input  logic                 i_col_step,
    input  logic                 i_row_skip,
    output agu_conv_pkg::ker_t   o_cur_ker_col,
    output logic                 o_part_first,
    output logic                 o_part_last,
    output logic                 o_ker_row_last,
    output logic                 o_ker_col_last,
    output logic                 o_ker_row_en,   // Kernel row done, stepped or skipped
    output logic                 o_row_en,
    output logic                 o_part_en,
    output logic                 o_in_piece_en,
    output logic                 o_work_done
);

    logic                 r_start;       // Clear lags start by one cycle
    agu_conv_pkg::piece_t r_row;         // Output row
    agu_conv_pkg::piece_t r_out_piece;
    agu_conv_pkg::part_t  r_part;
    agu_conv_pkg::piece_t r_in_piece;
    agu_conv_pkg::ker_t   r_ker_row;
    agu_conv_pkg::ker_t   r_ker_col;

    logic c_row_last;
    logic c_out_piece_last;
    logic c_in_piece_last;
    logic c_out_piece_en;
    logic c_final;                       // Last tap of the walk

    // Wrap detection
    assign c_row_last       = (r_row + 8'd1) == i_out_ylength;
    assign c_out_piece_last = (r_out_piece + 8'd1) == i_out_piece_num;
    assign o_part_last      = (r_part + 5'd1) == i_part_num;
    assign c_in_piece_last  = (r_in_piece + 8'd1) == i_in_piece_num;
    assign o_ker_row_last   = (r_ker_row + 4'd1) == i_kernel;
    assign o_ker_col_last   = (r_ker_col + 4'd1) == i_kernel;

    // -------------------------------------------------------------------------
    // Advance chain, inner to outer
    // -------------------------------------------------------------------------
    assign o_ker_row_en   = (i_col_step && o_ker_col_last) || i_row_skip;
    assign c_final        = o_ker_row_en && o_ker_row_last && c_in_piece_last
                            && o_part_last && c_out_piece_last && c_row_last;
    // Outer strobes held off at the end, no reload after the last tap
    assign o_in_piece_en  = o_ker_row_en && o_ker_row_last && !c_final;
    assign o_part_en      = o_in_piece_en && c_in_piece_last;
    assign c_out_piece_en = o_part_en && o_part_last;
    assign o_row_en       = c_out_piece_en && c_out_piece_last;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_row       <= '0;
            r_out_piece <= '0;
            r_part      <= '0;
            r_in_piece  <= '0;
            r_ker_row   <= '0;
            r_ker_col   <= '0;
        end else if (r_start) begin
            r_row       <= '0;
            r_out_piece <= '0;
            r_part      <= '0;
            r_in_piece  <= '0;
            r_ker_row   <= '0;
            r_ker_col   <= '0;
        end else begin
            if (i_col_step)
                r_ker_col <= o_ker_col_last ? 4'd0 : r_ker_col + 4'd1;
            if (o_ker_row_en)
                r_ker_row <= o_ker_row_last ? 4'd0 : r_ker_row + 4'd1;
            if (o_in_piece_en)
                r_in_piece <= c_in_piece_last ? 8'd0 : r_in_piece + 8'd1;
            if (o_part_en)
                r_part <= o_part_last ? 5'd0 : r_part + 5'd1;
            if (c_out_piece_en)
                r_out_piece <= c_out_piece_last ? 8'd0 : r_out_piece + 8'd1;
            if (o_row_en)
                r_row <= r_row + 8'd1;   // Never wraps, last row ends the walk
        end
    end

    // Start delay and done latch
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_start     <= 1'b0;
            o_work_done <= 1'b0;
        end else begin
            r_start <= i_start;
            if (i_start)
                o_work_done <= 1'b0;
            else if (c_final)
                o_work_done <= 1'b1;
        end
    end

    assign o_cur_ker_col = r_ker_col;
    assign o_part_first  = r_part == 5'd0;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the convolution address generator testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_agu_conv_baddr -f agu_conv_baddr.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/sim_tb 2>&1)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

//--- tb_agu_conv_baddr.sv
`timescale 1ns/10ps

module tb_agu_conv_baddr;

    localparam int NUM_RUNS = 12;

    logic                  i_clk;
    logic                  i_rst_n;
    agu_conv_pkg::addr_t   i_start_addr;
    agu_conv_pkg::piece_t  i_in_piece_num;
    agu_conv_pkg::piece_t  i_out_piece_num;
    agu_conv_pkg::piece_t  i_out_ylength;
    agu_conv_pkg::part_t   i_part_num;
    agu_conv_pkg::piece_t  i_in_ylength;
    agu_conv_pkg::piece_t  i_in_xlength;
    logic                  i_first_tiling;
    logic                  i_last_tiling;
    agu_conv_pkg::addr_t   i_one_line_size;
    agu_conv_pkg::addr_t   i_stride_line_size;
    agu_conv_pkg::pad_t    i_pad;
    agu_conv_pkg::stride_t i_stride;
    agu_conv_pkg::ker_t    i_kernel;
    logic                  i_start;
    logic                  i_fifo_ren;
    agu_conv_pkg::addr_t   o_base_addr;
    agu_conv_pkg::ker_t    o_ker_col;
    logic [1:0]            o_part_flag;
    logic                  o_pre_comp_rdy;
    logic                  o_endf;

    int seed;
    int cycles;         // Cycles since the run started
    int cycle_limit;
    int ren_pct;        // Read enable chance in percent
    int hold_cycles;    // Read enable forced low at run start
    int cfg_start_addr, cfg_in_pieces, cfg_out_pieces, cfg_out_rows, cfg_parts;
    int cfg_in_ylen, cfg_xlen, cfg_pad, cfg_stride, cfg_kernel, cfg_line;
    int cfg_first, cfg_last;

    // Expected entries, oldest first
    agu_conv_pkg::addr_t exp_addr [$];
    agu_conv_pkg::ker_t  exp_col [$];
    logic [1:0]          exp_flag [$];

    agu_conv_baddr i_dut (.*);

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    function automatic int pick(input int lo, input int hi);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return lo + (r % (hi - lo + 1));
    endfunction

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic tick();
        @(posedge i_clk);  // Outputs read here are pre-edge values
        cycles++;
        assert (cycles <= cycle_limit)
        else report_fail($sformatf("Timeout after %0d cycles in one run", cycles));
    endtask

    // Walk the loop nest, column innermost
    task automatic build_model();
        int row, op, pt, ip, kr, kc, in_row, addr;
        bit pad_row;
        exp_addr.delete();
        exp_col.delete();
        exp_flag.delete();
        for (row = 0; row < cfg_out_rows; row++)
            for (op = 0; op < cfg_out_pieces; op++)
                for (pt = 0; pt < cfg_parts; pt++)
                    for (ip = 0; ip < cfg_in_pieces; ip++)
                        for (kr = 0; kr < cfg_kernel; kr++) begin
                            in_row  = row * cfg_stride + kr;
                            pad_row = (cfg_first && in_row < cfg_pad)
                                      || (cfg_first && cfg_last
                                          && in_row >= cfg_in_ylen + cfg_pad)
                                      || (!cfg_first && cfg_last && in_row >= cfg_in_ylen);
                            if (!pad_row)
                                for (kc = 0; kc < cfg_kernel; kc++) begin
                                    addr = cfg_start_addr
                                           - (cfg_first ? cfg_pad * cfg_line : 0)
                                           + row * cfg_line * cfg_stride
                                           + pt * agu_conv_pkg::PE_COLS * cfg_stride
                                           + ip * cfg_xlen - cfg_pad
                                           + kr * cfg_line + kc;
                                    exp_addr.push_back(agu_conv_pkg::addr_t'(addr));
                                    exp_col.push_back(agu_conv_pkg::ker_t'(kc));
                                    exp_flag.push_back({pt == 0, pt == cfg_parts - 1});
                                end
                        end
    endtask

    task automatic choose_config(input int run);
        cfg_start_addr = pick(0, 4095);
        cfg_kernel     = pick(1, 3);
        cfg_stride     = pick(1, 2);
        cfg_pad        = pick(0, 2);
        cfg_out_rows   = pick(1, 3);
        cfg_out_pieces = pick(1, 2);
        cfg_parts      = pick(1, 3);
        cfg_in_pieces  = pick(1, 3);
        cfg_xlen       = pick(1, 20);
        cfg_in_ylen    = pick(1, 8);
        cfg_line       = cfg_xlen * cfg_in_pieces;
        cfg_first      = (run % 4 == 1) || (run % 4 == 2);   // Tiling order none first both last
        cfg_last       = (run % 4 == 2) || (run % 4 == 3);
        ren_pct        = pick(30, 95);
        hold_cycles    = (run % 3 == 2) ? 300 : 0;         // Long back-pressure
    endtask

    task automatic check_head();
        assert (o_base_addr == exp_addr[0])
        else report_fail($sformatf("ERR o_base_addr got %h expected %h",
                                   o_base_addr, exp_addr[0]));
        assert (o_ker_col == exp_col[0])
        else report_fail($sformatf("ERR o_ker_col got %h expected %h",
                                   o_ker_col, exp_col[0]));
        assert (o_part_flag == exp_flag[0])
        else report_fail($sformatf("ERR o_part_flag got %h expected %h",
                                   o_part_flag, exp_flag[0]));
        void'(exp_addr.pop_front());
        void'(exp_col.pop_front());
        void'(exp_flag.pop_front());
    endtask

    // ------------------------------------------------------------------------
    // One run, start pulse to o_endf
    // ------------------------------------------------------------------------
    task automatic do_run(input int run);
        bit done;
        choose_config(run);
        build_model();
        $display("Run %0d tiling %0d%0d with %0d entries", run, cfg_first, cfg_last,
                 exp_addr.size());
        cycles      = 0;
        cycle_limit = 20 * exp_addr.size() + 2000;
        i_start_addr       <= agu_conv_pkg::addr_t'(cfg_start_addr);
        i_in_piece_num     <= agu_conv_pkg::piece_t'(cfg_in_pieces);
        i_out_piece_num    <= agu_conv_pkg::piece_t'(cfg_out_pieces);
        i_out_ylength      <= agu_conv_pkg::piece_t'(cfg_out_rows);
        i_part_num         <= agu_conv_pkg::part_t'(cfg_parts);
        i_in_ylength       <= agu_conv_pkg::piece_t'(cfg_in_ylen);
        i_in_xlength       <= agu_conv_pkg::piece_t'(cfg_xlen);
        i_first_tiling     <= cfg_first[0];
        i_last_tiling      <= cfg_last[0];
        i_one_line_size    <= agu_conv_pkg::addr_t'(cfg_line);
        i_stride_line_size <= agu_conv_pkg::addr_t'(cfg_line * cfg_stride);
        i_pad              <= agu_conv_pkg::pad_t'(cfg_pad);
        i_stride           <= agu_conv_pkg::stride_t'(cfg_stride);
        i_kernel           <= agu_conv_pkg::ker_t'(cfg_kernel);
        i_fifo_ren         <= 1'b0;
        i_start            <= 1'b1;
        tick();
        i_start <= 1'b0;
        assert (!o_endf) else report_fail("o_endf still high during the start pulse");
        tick();
        assert (!o_endf) else report_fail("o_endf did not clear after the start pulse");
        while (exp_addr.size() > 0) begin
            tick();
            assert (!o_endf)
            else report_fail($sformatf("o_endf high with %0d entries still expected",
                                       exp_addr.size()));
            if (i_fifo_ren && o_pre_comp_rdy)
                check_head();
            if (cycles <= hold_cycles)
                i_fifo_ren <= 1'b0;
            else
                i_fifo_ren <= (pick(0, 99) < ren_pct);
        end
        i_fifo_ren <= 1'b0;
        // Nothing more may show up before o_endf
        done = 1'b0;
        while (!done) begin
            tick();
            assert (!o_pre_comp_rdy)
            else report_fail("DUT presented an entry beyond the expected sequence");
            done = o_endf;
        end
        repeat (3) begin
            tick();
            assert (o_endf) else report_fail("o_endf dropped before the next start");
        end
    endtask

    initial begin
        seed        = 83106;
        cycles      = 0;
        cycle_limit = 2000;
        i_rst_n            = 1'b0;
        i_start_addr       = '0;
        i_in_piece_num     = '0;
        i_out_piece_num    = '0;
        i_out_ylength      = '0;
        i_part_num         = '0;
        i_in_ylength       = '0;
        i_in_xlength       = '0;
        i_first_tiling     = 1'b0;
        i_last_tiling      = 1'b0;
        i_one_line_size    = '0;
        i_stride_line_size = '0;
        i_pad              = '0;
        i_stride           = '0;
        i_kernel           = '0;
        i_start            = 1'b0;
        i_fifo_ren         = 1'b0;
        repeat (10) @(posedge i_clk);
        i_rst_n <= 1'b1;
        repeat (3) begin
            tick();
            assert (!o_pre_comp_rdy && !o_endf)
            else report_fail("o_pre_comp_rdy or o_endf high after reset");
        end
        for (int run = 0; run < NUM_RUNS; run++)
            do_run(run);
        $display("Testbench passed");
        $finish;
    end

endmodule
